// ==== all.f ====
console_pkg.sv
screen_buffer.sv
teletype.sv
console_apb_regs.sv
text_console.sv
text_console_props.sv
tb_text_console.sv

// ==== console_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module console_apb_regs
   import console_pkg::*;
#(
   parameter int COLS = 32,
   parameter int ROWS = 19
) (
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire                          psel,
   input  wire                          penable,
   input  wire                          pwrite,
   input  wire [12:0]                   paddr,
   input  wire [31:0]                   pwdata,
   output logic [31:0]                  prdata,
   output logic                         pready,
   output logic                         pslverr,
   output cmd_byte_t                    tty_byte,
   output logic                         tty_valid,
   input  wire                          tty_ready,
   input  wire [$clog2(COLS*ROWS)-1:0]  cursor,
   output logic                         rd_en,
   output logic [$clog2(COLS*ROWS)-1:0] rd_addr,
   input  wire char_t                   rd_data
);

   localparam int CELLS = COLS * ROWS;
   localparam int AW    = $clog2(CELLS);

   logic        access;
   logic        hit_data;
   logic        hit_status;
   logic        hit_cursor;
   logic        hit_screen;
   logic        legal;
   logic [12:0] scr_off;
   logic [10:0] cell_idx;
   logic        rd_pending;  // Screen read issued, data due this cycle

   // ----------------------------------------------------------------------
   // Address decode
   // ----------------------------------------------------------------------
   assign access     = psel & penable;
   assign hit_data   = (paddr == REG_DATA);
   assign hit_status = (paddr == REG_STATUS);
   assign hit_cursor = (paddr == REG_CURSOR);

   assign scr_off    = paddr - SCREEN_BASE;
   assign cell_idx   = scr_off[12:2];
   assign hit_screen = (paddr >= SCREEN_BASE) && (scr_off[1:0] == 2'b00) &&
                       (32'(cell_idx) < CELLS);

   // Only DATA takes writes; DATA itself is write-only
   assign legal = pwrite ? hit_data : (hit_status | hit_cursor | hit_screen);

   // ----------------------------------------------------------------------
   // Teletype hand-off and screen read port
   // ----------------------------------------------------------------------
   assign tty_byte.chr = pwdata[7:0];
   assign tty_valid    = access & pwrite & hit_data;

   assign rd_en   = access & ~pwrite & hit_screen & ~rd_pending;
   assign rd_addr = cell_idx[AW-1:0];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_pending <= 1'b0;
      end else begin
         rd_pending <= rd_en;  // One wait state per screen read
      end
   end

   // ----------------------------------------------------------------------
   // Completion and read data
   // ----------------------------------------------------------------------
   always_comb begin
      pready = 1'b0;
      if (access) begin
         if (!legal) begin
            pready = 1'b1;  // Error ends at once
         end else if (pwrite) begin
            pready = tty_ready;  // Stall while teletype busy
         end else if (hit_screen) begin
            pready = rd_pending;
         end else begin
            pready = 1'b1;
         end
      end
   end

   assign pslverr = access & ~legal;

   always_comb begin
      prdata = '0;
      if (hit_status) begin
         prdata[0] = ~tty_ready;  // Busy
      end else if (hit_cursor) begin
         prdata[AW-1:0] = cursor;
      end else if (hit_screen) begin
         prdata[7:0] = rd_data;
      end
   end

endmodule

`default_nettype wire

// ==== console_pkg.sv ====
`default_nettype none

package console_pkg;

   // ----------------------------------------------------------------------
   // Character and command byte
   // ----------------------------------------------------------------------
   typedef logic [7:0] char_t;

   // Same byte seen as a code in idle, as a row or column after AT
   typedef union packed {
      char_t chr;
      struct packed {
         logic [2:0] spare;
         logic [4:0] coord;
      } pos;
   } cmd_byte_t;

   // Control codes
   localparam char_t CODE_AT   = 8'd22;  // Followed by row, column
   localparam char_t CODE_CR   = 8'd13;
   localparam char_t CODE_HOME = 8'd12;

   localparam char_t CHAR_BLANK = 8'h20;  // Fill for the clear

   // ----------------------------------------------------------------------
   // APB offsets
   // ----------------------------------------------------------------------
   localparam logic [12:0] REG_DATA    = 13'h000;
   localparam logic [12:0] REG_STATUS  = 13'h004;
   localparam logic [12:0] REG_CURSOR  = 13'h008;
   localparam logic [12:0] SCREEN_BASE = 13'h1000;  // One cell per word

endpackage

`default_nettype wire

// ==== console_vectors.txt ====
# W offset data | R offset expected | E offset expected_pslverr dir (1 = write)
# All fields hex; screen cell n sits at offset 1000 + 4*n
# Back-pressure: busy during the clear, then a stalled DATA write
W 000 0C
R 004 1
W 000 41
R 004 0
R 1000 41
R 008 1
# Clear fills every cell with blanks, cursor back at 0
W 000 0C
W 000 16
W 000 00
W 000 00
R 1000 20
R 14B0 20
R 197C 20
R 008 0
# Printable string, then a print at the last cell wraps
W 000 48
W 000 45
W 000 4C
R 008 3
R 1000 48
R 1004 45
R 1008 4C
W 000 16
W 000 12
W 000 1F
R 008 25F
W 000 5A
R 008 0
R 197C 5A
# AT positioning, row out of range lands on row 0
W 000 16
W 000 05
W 000 07
R 008 A7
W 000 2A
R 129C 2A
R 008 A8
W 000 16
W 000 19
W 000 09
R 008 9
# CR to next row, and from the last row back to 0
W 000 0D
R 008 20
W 000 16
W 000 12
W 000 04
R 008 244
W 000 0D
R 008 0
# Errors leave the cursor alone
W 000 16
W 000 02
W 000 03
E 00C 1 0
E 1980 1 0
E 004 1 1
R 008 43

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f all.f --top-module tb_text_console -o sim_tb \
   && ./obj_dir/sim_tb | grep -q "^sim passed$" \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

// ==== screen_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module screen_buffer
   import console_pkg::*;
#(
   parameter int COLS = 32,
   parameter int ROWS = 19
) (
   input  wire                          clk,
   input  wire                          wr_en,
   input  wire [$clog2(COLS*ROWS)-1:0]  wr_addr,
   input  wire char_t                   wr_data,
   input  wire                          rd_en,
   input  wire [$clog2(COLS*ROWS)-1:0]  rd_addr,
   output char_t                        rd_data
);

   localparam int CELLS = COLS * ROWS;

   char_t mem [0:CELLS-1];  // Row-major, COLS cells per row

   // Old data on a same-cell read and write
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

`default_nettype wire

// ==== tb_text_console.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_text_console
   import console_pkg::*;
();

   localparam int COLS    = 32;
   localparam int ROWS    = 19;
   localparam int HALF    = 5;
   localparam int TIMEOUT = 2000;  // Cycles, well over one full clear

   logic        clk;
   logic        arst_n;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [12:0] paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;

   int          fd;
   int          n_checks;

   text_console #(
      .COLS (COLS),
      .ROWS (ROWS)
   ) uut (
      .clk     (clk),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #HALF clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // Error exit and compare tasks
   // ----------------------------------------------------------------------
   task automatic abort_run();
      $display("sim failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_char(input string name, input char_t exp, input char_t got);
      if (got !== exp) begin
         $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
      if (got !== exp) begin
         $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_err(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, got);
         abort_run();
      end
   endtask

   // ----------------------------------------------------------------------
   // APB master, entered and left on a falling edge
   // ----------------------------------------------------------------------
   task automatic finish_access(output logic [31:0] rdata, output logic err);
      int cycles;
      bit done;
      cycles = 0;
      done   = 1'b0;
      while (!done) begin
         #(HALF - 1);  // Sample just before the rising edge
         if (pready) begin
            done  = 1'b1;
            rdata = prdata;
            err   = pslverr;
         end else if (cycles == TIMEOUT) begin
            $display("Timeout: no pready within %0d cycles at offset %h", TIMEOUT, paddr);
            abort_run();
         end
         cycles++;
         @(negedge clk);
      end
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [12:0] addr, input logic [31:0] data,
                            output logic err);
      logic [31:0] rd_ignored;
      psel    = 1'b1;  // Setup phase
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      finish_access(rd_ignored, err);
   endtask

   task automatic apb_read(input logic [12:0] addr, output logic [31:0] rdata,
                           output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      finish_access(rdata, err);
   endtask

   // ----------------------------------------------------------------------
   // Vector player
   // ----------------------------------------------------------------------
   initial begin
      byte              op;
      int               code;
      logic [31:0]      f_off;
      logic [31:0]      f_val;
      logic [31:0]      f_dir;
      logic [31:0]      rdata;
      logic             err;
      string            reg_name;
      reg [8*128-1:0]   rest;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      arst_n   = 1'b0;
      n_checks = 0;
      repeat (16) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      fd = $fopen("console_vectors.txt", "r");
      if (fd == 0) begin
         $display("Cannot open console_vectors.txt for reading");
         abort_run();
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, " %c", op);
         if (code == 1) begin
            if (op == "#") begin
               code = $fgets(rest, fd);  // Comment line
            end else if (op == "W") begin
               code = $fscanf(fd, "%h %h", f_off, f_val);
               apb_write(f_off[12:0], f_val, err);
               check_err("pslverr", 1'b0, err);
            end else if (op == "R") begin
               code = $fscanf(fd, "%h %h", f_off, f_val);
               apb_read(f_off[12:0], rdata, err);
               check_err("pslverr", 1'b0, err);
               if (f_off[12:0] >= SCREEN_BASE) begin
                  check_char("screen cell", f_val[7:0], rdata[7:0]);
               end else begin
                  reg_name = (f_off[12:0] == REG_STATUS) ? "status" : "cursor";
                  check_word(reg_name, f_val, rdata);
               end
               n_checks++;
            end else if (op == "E") begin
               code = $fscanf(fd, "%h %h %h", f_off, f_val, f_dir);
               if (f_dir[0]) begin
                  apb_write(f_off[12:0], 32'h0, err);
               end else begin
                  apb_read(f_off[12:0], rdata, err);
               end
               check_err("pslverr", f_val[0], err);
               n_checks++;
            end else begin
               $display("Unknown operation '%c' in console_vectors.txt", op);
               abort_run();
            end
         end
      end
      $fclose(fd);

      if (n_checks > 0) begin
         $display("sim passed");
         $finish;
      end else begin
         $display("No checks found in console_vectors.txt");
         abort_run();
      end
   end

endmodule

`default_nettype wire

// ==== teletype.sv ====
`timescale 1ns/1ps
`default_nettype none

module teletype
   import console_pkg::*;
#(
   parameter int COLS = 32,
   parameter int ROWS = 19
) (
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire cmd_byte_t               tty_byte,
   input  wire                          tty_valid,
   output logic                         tty_ready,
   output logic [$clog2(COLS*ROWS)-1:0] cursor,
   output logic                         wr_en,
   output logic [$clog2(COLS*ROWS)-1:0] wr_addr,
   output char_t                        wr_data
);

   localparam int CELLS = COLS * ROWS;
   localparam int AW    = $clog2(CELLS);
   localparam int CW    = $clog2(COLS);  // Column bits, COLS a power of two
   localparam int RW    = AW - CW;       // Row bits

   localparam logic [2:0] ST_IDLE  = 3'd0;
   localparam logic [2:0] ST_ROW   = 3'd1;  // Waiting for AT row byte
   localparam logic [2:0] ST_COL   = 3'd2;  // Waiting for AT column byte
   localparam logic [2:0] ST_EXEC  = 3'd3;  // Print or CR
   localparam logic [2:0] ST_CLEAR = 3'd4;

   logic [2:0]    state;
   char_t         pend;      // Byte held for the EXEC cycle
   logic [RW-1:0] row_q;     // Pending AT row
   logic [AW-1:0] clr_addr;
   logic [RW-1:0] cur_row;
   logic          accept;
   logic          pend_cr;

   assign accept  = tty_valid & tty_ready;
   assign cur_row = cursor[AW-1:CW];
   assign pend_cr = (pend == CODE_CR);

   // ----------------------------------------------------------------------
   // Handshake and write port
   // ----------------------------------------------------------------------
   assign tty_ready = (state == ST_IDLE) || (state == ST_ROW) || (state == ST_COL);
   assign wr_en     = (state == ST_CLEAR) || ((state == ST_EXEC) && !pend_cr);
   assign wr_addr   = (state == ST_CLEAR) ? clr_addr : cursor;
   assign wr_data   = (state == ST_CLEAR) ? CHAR_BLANK : pend;

   always_ff @(posedge clk) begin
      if (accept && state == ST_IDLE) begin
         pend <= tty_byte.chr;
      end
   end

   // ----------------------------------------------------------------------
   // Command FSM and cursor
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= ST_IDLE;
         cursor   <= '0;
         row_q    <= '0;
         clr_addr <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (accept) begin
                  case (tty_byte.chr)
                     CODE_AT: begin
                        state <= ST_ROW;
                     end
                     CODE_HOME: begin
                        clr_addr <= '0;
                        state    <= ST_CLEAR;
                     end
                     default: begin
                        state <= ST_EXEC;  // CR or printable
                     end
                  endcase
               end
            end
            ST_ROW: begin
               if (accept) begin
                  // Out-of-range row lands on row 0
                  if (32'(tty_byte.pos.coord) >= ROWS) begin
                     row_q <= '0;
                  end else begin
                     row_q <= tty_byte.pos.coord[RW-1:0];
                  end
                  state <= ST_COL;
               end
            end
            ST_COL: begin
               if (accept) begin
                  cursor <= {row_q, tty_byte.pos.coord[CW-1:0]};
                  state  <= ST_IDLE;
               end
            end
            ST_EXEC: begin
               if (pend_cr) begin
                  if (cur_row == RW'(ROWS - 1)) begin
                     cursor <= '0;  // Wrap from last row
                  end else begin
                     cursor <= {cur_row + RW'(1), {CW{1'b0}}};
                  end
               end else if (cursor == AW'(CELLS - 1)) begin
                  cursor <= '0;
               end else begin
                  cursor <= cursor + AW'(1);
               end
               state <= ST_IDLE;
            end
            ST_CLEAR: begin
               if (clr_addr == AW'(CELLS - 1)) begin
                  cursor <= '0;
                  state  <= ST_IDLE;
               end else begin
                  clr_addr <= clr_addr + AW'(1);
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== text_console.sv ====
`timescale 1ns/1ps
`default_nettype none

module text_console
   import console_pkg::*;
#(
   parameter int COLS = 32,  // Power of two, up to 32
   parameter int ROWS = 19   // Up to 32
) (
   input  wire         clk,
   input  wire         arst_n,
   input  wire         psel,
   input  wire         penable,
   input  wire         pwrite,
   input  wire  [12:0] paddr,
   input  wire  [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr
);

   localparam int AW = $clog2(COLS * ROWS);

   // Register block to teletype
   cmd_byte_t     tty_byte;
   logic          tty_valid;
   logic          tty_ready;
   logic [AW-1:0] cursor;

   // Screen memory ports
   logic          rd_en;
   logic [AW-1:0] rd_addr;
   char_t         rd_data;
   logic          wr_en;
   logic [AW-1:0] wr_addr;
   char_t         wr_data;

   console_apb_regs #(
      .COLS (COLS),
      .ROWS (ROWS)
   ) u_regs (
      .clk       (clk),
      .arst_n    (arst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .tty_byte  (tty_byte),
      .tty_valid (tty_valid),
      .tty_ready (tty_ready),
      .cursor    (cursor),
      .rd_en     (rd_en),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data)
   );

   teletype #(
      .COLS (COLS),
      .ROWS (ROWS)
   ) u_tty (
      .clk       (clk),
      .arst_n    (arst_n),
      .tty_byte  (tty_byte),
      .tty_valid (tty_valid),
      .tty_ready (tty_ready),
      .cursor    (cursor),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data)
   );

   screen_buffer #(
      .COLS (COLS),
      .ROWS (ROWS)
   ) u_screen (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

// ==== text_console_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module console_apb_props
   import console_pkg::*;
(
   input wire            clk,
   input wire            arst_n,
   input wire            psel,
   input wire            penable,
   input wire            pready,
   input wire            pslverr,
   input wire            tty_valid,
   input wire            tty_ready,
   input wire cmd_byte_t tty_byte
);

   // ----------------------------------------------------------------------
   // APB completion
   // ----------------------------------------------------------------------
   a_ready_in_access : assert property (@(posedge clk) disable iff (!arst_n)
      pready |-> (psel && penable))
      else $error("pready high outside an APB access phase");

   a_err_with_ready : assert property (@(posedge clk) disable iff (!arst_n)
      pslverr |-> pready)
      else $error("pslverr high without pready");

   // ----------------------------------------------------------------------
   // Teletype hand-off
   // ----------------------------------------------------------------------
   a_valid_held : assert property (@(posedge clk) disable iff (!arst_n)
      (tty_valid && !tty_ready) |=> tty_valid)
      else $error("tty_valid dropped before acceptance");

   a_byte_stable : assert property (@(posedge clk) disable iff (!arst_n)
      (tty_valid && !tty_ready) |=> $stable(tty_byte.chr))
      else $error("tty_byte changed while stalled");

endmodule

bind console_apb_regs console_apb_props u_props (
   .clk       (clk),
   .arst_n    (arst_n),
   .psel      (psel),
   .penable   (penable),
   .pready    (pready),
   .pslverr   (pslverr),
   .tty_valid (tty_valid),
   .tty_ready (tty_ready),
   .tty_byte  (tty_byte)
);

`default_nettype wire
